// File: hdl/i2c_macros.svh
// I2C management block constants
// Bus field positions, command codes, CSR offsets, default block select
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// Bus address fields
`define I2C_BUS_ADRS_BIT   31
`define I2C_CMD_HI         31
`define I2C_CMD_LO         30
`define I2C_BLK_HI         23
`define I2C_BLK_LO         16
`define I2C_CSR_HI         15
`define I2C_CSR_LO         0

// Command codes, 0 and 3 ignored
`define I2C_CMD_WRITE      2'd1
`define I2C_CMD_READ       2'd2

// CSR offsets
`define I2C_CSR_CTRL       16'h0000
`define I2C_CSR_DIV        16'h0004
`define I2C_CSR_TARGET     16'h0008
`define I2C_CSR_XFER       16'h000C
`define I2C_CSR_STATUS     16'h0010

`define I2C_DEF_BLOCK_ADRS 8'h01

`endif

// File: hdl/i2cPkg.sv
// I2C block types
// Vector widths and FSM encodings shared by CSR, sequencer and bit generator
`default_nettype none

package i2cPkg;

	typedef logic [31:0] busDataT;	// Bus read and write data
	typedef logic [31:0] busAdrsT;	// Cmd, block and offset fields
	typedef logic [15:0] csrAdrsT;	// Register offset
	typedef logic [15:0] divT;		// Quarter period in sysClk cycles
	typedef logic [7:0]  byteT;
	typedef logic [6:0]  tgtAdrsT;	// 7-bit target address

	// Bit-level symbol kind
	typedef enum logic [1:0] {SymStart, SymStop, SymBit} symT;

	// Transaction sequencer
	typedef enum logic [2:0] {
		Idle, Start, AdrsByte, AdrsAck, DataByte, DataAck, Stop
	} byteStateT;

	// Quarter phases of one symbol
	typedef enum logic [2:0] {QIdle, Q0, Q1, Q2, Q3} bitStateT;

endpackage

`default_nettype wire

// File: hdl/i2cCsr.sv
// I2C CSR unit
// Decodes slave-bus strobes, holds control registers, answers reads
`timescale 1ns/1ps
`default_nettype none
`include "i2c_macros.svh"

module i2cCsr #(
	parameter logic [7:0] blockAdrs = `I2C_DEF_BLOCK_ADRS
)(
	input  wire               sysClk,
	input  wire               arstN,
	input  i2cPkg::busAdrsT   usiAdrs,	// {31:30} cmd, {23:16} block, {15:0} offset
	input  i2cPkg::busDataT   usiWd,
	input  wire               usiWCke,	// One-cycle command strobe
	output i2cPkg::busDataT   usiRd,
	output logic              usiVd,
	output logic              i2cEn,
	output i2cPkg::divT       div,
	output i2cPkg::tgtAdrsT   tgtAdrs,
	output i2cPkg::byteT      txByte,
	output logic              rdSel,
	output logic              xferGo,	// Accepted transfer request
	input  wire               busy,
	input  i2cPkg::byteT      rxByte,
	input  wire               nackPulse
);

	//------------------------------------------------------------
	// Strobe decode
	//------------------------------------------------------------
	logic [1:0]      cmd;
	logic            blkHit;
	i2cPkg::csrAdrsT csrAdrs;
	logic            wrHit;
	logic            rdHit;
	logic            xferOk;
	logic            nack;		// Sticky NACK
	i2cPkg::busDataT rdMux;

	assign cmd     = usiAdrs[`I2C_CMD_HI:`I2C_CMD_LO];
	assign blkHit  = (usiAdrs[`I2C_BLK_HI:`I2C_BLK_LO] == blockAdrs);
	assign csrAdrs = usiAdrs[`I2C_CSR_HI:`I2C_CSR_LO];
	assign wrHit   = usiWCke && blkHit && (cmd == `I2C_CMD_WRITE);
	assign rdHit   = usiWCke && blkHit && (cmd == `I2C_CMD_READ);
	// Launch only when enabled and engine free, back-to-back go blocked too
	assign xferOk  = wrHit && (csrAdrs == `I2C_CSR_XFER) && i2cEn && !busy && !xferGo;

	//------------------------------------------------------------
	// Register writes
	//------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			i2cEn   <= 1'b0;
			div     <= '0;
			tgtAdrs <= '0;
			txByte  <= '0;
			rdSel   <= 1'b0;
			xferGo  <= 1'b0;
			nack    <= 1'b0;
		end
		else
		begin
			xferGo <= xferOk;							// One-cycle pulse
			if (wrHit && csrAdrs == `I2C_CSR_CTRL)   i2cEn   <= usiWd[0];
			if (wrHit && csrAdrs == `I2C_CSR_DIV)    div     <= usiWd[15:0];
			if (wrHit && csrAdrs == `I2C_CSR_TARGET) tgtAdrs <= usiWd[6:0];
			if (xferOk)
			begin
				txByte <= usiWd[7:0];
				rdSel  <= usiWd[8];
			end
			// Cleared per accepted transfer, set by any ack-slot NACK
			if (xferGo)         nack <= 1'b0;
			else if (nackPulse) nack <= 1'b1;
		end
	end

	//------------------------------------------------------------
	// Read path, one cycle latency
	//------------------------------------------------------------
	always_comb
	begin
		case (csrAdrs)
			`I2C_CSR_CTRL:   rdMux = {31'd0, i2cEn};
			`I2C_CSR_DIV:    rdMux = {16'd0, div};
			`I2C_CSR_TARGET: rdMux = {25'd0, tgtAdrs};
			`I2C_CSR_XFER:   rdMux = {23'd0, rdSel, txByte};
			`I2C_CSR_STATUS: rdMux = {16'd0, rxByte, 6'd0, nack, busy};
			default:         rdMux = '0;			// Unknown offset reads zero
		endcase
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			usiRd <= '0;
			usiVd <= 1'b0;
		end
		else
		begin
			usiVd <= rdHit;
			usiRd <= rdHit ? rdMux : '0;			// Zero outside the valid cycle
		end
	end

endmodule

`default_nettype wire

// File: hdl/i2cByteCtrl.sv
// I2C transaction sequencer
// START, address + R/W, ack, one data byte, ack/NACK, STOP
`timescale 1ns/1ps
`default_nettype none

module i2cByteCtrl (
	input  wire              sysClk,
	input  wire              arstN,
	input  wire              i2cEn,
	input  wire              xferGo,
	input  i2cPkg::tgtAdrsT  tgtAdrs,
	input  i2cPkg::byteT     txByte,
	input  wire              rdSel,		// Stable while busy
	output logic             busy,
	output i2cPkg::byteT     rxByte,
	output logic             nackPulse,
	output logic             symGo,
	output i2cPkg::symT      sym,
	output logic             txBit,
	input  wire              symDone,
	input  wire              rxBit
);

	i2cPkg::byteStateT state;
	logic [2:0]        bitCnt;		// Bits left in current byte
	i2cPkg::byteT      shReg;		// Shifts out MSB first and takes rxBit in at LSB
	logic              pending;		// Symbol issued and awaiting symDone

	assign busy = (state != i2cPkg::Idle);

	//------------------------------------------------------------
	// Symbol for current state
	//------------------------------------------------------------
	always_comb
	begin
		sym   = i2cPkg::SymBit;
		txBit = 1'b1;									// Released by default
		case (state)
			i2cPkg::Start:    sym = i2cPkg::SymStart;
			i2cPkg::Stop:     sym = i2cPkg::SymStop;
			i2cPkg::AdrsByte: txBit = shReg[7];
			i2cPkg::DataByte: txBit = rdSel ? 1'b1 : shReg[7];	// Read leaves SDA to target
			default:          txBit = 1'b1;				// Released in ack slots and for read NACK
		endcase
	end

	//------------------------------------------------------------
	// Sequencer FSM
	//------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state     <= i2cPkg::Idle;
			bitCnt    <= '0;
			shReg     <= '0;
			pending   <= 1'b0;
			symGo     <= 1'b0;
			nackPulse <= 1'b0;
			rxByte    <= '0;
		end
		else
		begin
			symGo     <= 1'b0;
			nackPulse <= 1'b0;
			if (state == i2cPkg::Idle)
			begin
				if (xferGo && i2cEn)
				begin
					state   <= i2cPkg::Start;
					pending <= 1'b0;
					shReg   <= {tgtAdrs, rdSel};				// Address byte loaded at launch
				end
			end
			else if (!pending)
			begin
				symGo   <= 1'b1;							// Issue next symbol
				pending <= 1'b1;
			end
			else if (symDone)
			begin
				pending <= 1'b0;
				if (!i2cEn && state != i2cPkg::Stop)
					state <= i2cPkg::Stop;					// Abort through STOP to free the bus
				else
				begin
					case (state)
						i2cPkg::Start:
						begin
							state  <= i2cPkg::AdrsByte;
							bitCnt <= 3'd7;
						end
						i2cPkg::AdrsByte, i2cPkg::DataByte:
						begin
							shReg <= {shReg[6:0], rxBit};
							if (bitCnt == 3'd0)
								state <= (state == i2cPkg::AdrsByte) ? i2cPkg::AdrsAck
								                                      : i2cPkg::DataAck;
							else
								bitCnt <= bitCnt - 3'd1;
						end
						i2cPkg::AdrsAck:
						begin
							nackPulse <= rxBit;				// NACK flagged but length kept
							shReg     <= txByte;
							bitCnt    <= 3'd7;
							state     <= i2cPkg::DataByte;
						end
						i2cPkg::DataAck:
						begin
							if (rdSel) rxByte    <= shReg;
							else       nackPulse <= rxBit;
							state <= i2cPkg::Stop;
						end
						default: state <= i2cPkg::Idle;		// Stop finished
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/i2cBitCtrl.sv
// I2C bit generator
// Four quarter phases per symbol, open-drain SDA, SCL driven
`timescale 1ns/1ps
`default_nettype none

module i2cBitCtrl (
	input  wire           sysClk,
	input  wire           arstN,
	input  i2cPkg::divT   div,		// Quarter period, taken at symGo
	input  wire           symGo,
	input  i2cPkg::symT   sym,
	input  wire           txBit,
	output logic          symDone,
	output logic          rxBit,
	output logic          scl,
	inout  wire           sda
);

	i2cPkg::bitStateT state;
	i2cPkg::bitStateT nextPh;
	i2cPkg::divT      cnt;		// Cycles within quarter
	i2cPkg::divT      divReg;
	i2cPkg::symT      symReg;
	logic             bitReg;
	logic             sdaReg;		// 1 = released

	// {scl, sda} for a phase
	function automatic logic [1:0] levels(i2cPkg::symT s, logic b, i2cPkg::bitStateT ph);
		logic [1:0] lv;
		case (s)
			i2cPkg::SymStart: lv = (ph == i2cPkg::Q3) ? 2'b00 : (ph == i2cPkg::Q2) ? 2'b10 : 2'b11;	// SDA falls, SCL high
			i2cPkg::SymStop:  lv = (ph == i2cPkg::Q0) ? 2'b00 : (ph == i2cPkg::Q1) ? 2'b10 : 2'b11;	// SDA rises, SCL high
			default:          lv = {(ph == i2cPkg::Q1 || ph == i2cPkg::Q2), b};	// Data bit
		endcase
		return lv;
	endfunction

	always_comb
	begin
		case (state)
			i2cPkg::Q0: nextPh = i2cPkg::Q1;
			i2cPkg::Q1: nextPh = i2cPkg::Q2;
			i2cPkg::Q2: nextPh = i2cPkg::Q3;
			default:    nextPh = i2cPkg::QIdle;
		endcase
	end

	//------------------------------------------------------------
	// Quarter stepping, lines hold between symbols
	//------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= i2cPkg::QIdle;
			cnt     <= '0;
			symDone <= 1'b0;
			rxBit   <= 1'b0;
			scl     <= 1'b1;
			sdaReg  <= 1'b1;
		end
		else
		begin
			symDone <= 1'b0;
			if (state == i2cPkg::QIdle)
			begin
				if (symGo)
				begin
					state         <= i2cPkg::Q0;
					cnt           <= '0;
					{scl, sdaReg} <= levels(sym, txBit, i2cPkg::Q0);
				end
			end
			else if (cnt == divReg - 16'd1)
			begin
				cnt <= '0;
				if (state == i2cPkg::Q1) rxBit <= sda;		// Middle of SCL high
				if (state == i2cPkg::Q3) symDone <= 1'b1;
				else {scl, sdaReg} <= levels(symReg, bitReg, nextPh);
				state <= nextPh;
			end
			else
				cnt <= cnt + 16'd1;
		end
	end

	// Symbol latched at issue
	always_ff @(posedge sysClk)
	begin
		if (state == i2cPkg::QIdle && symGo)
		begin
			divReg <= div;
			symReg <= sym;
			bitReg <= txBit;
		end
	end

	assign sda = sdaReg ? 1'bz : 1'b0;	// Open drain

endmodule

`default_nettype wire

// File: hdl/i2cBlock.sv
// I2C management block top
// CSR unit feeding a byte sequencer and bit-level SCL/SDA generator
`timescale 1ns/1ps
`default_nettype none
`include "i2c_macros.svh"

module i2cBlock #(
	parameter logic [7:0] blockAdrs = `I2C_DEF_BLOCK_ADRS
)(
	input  wire                         sysClk,
	input  wire                         arstN,
	input  wire [`I2C_BUS_ADRS_BIT:0]   usiAdrs,
	input  wire [31:0]                  usiWd,
	input  wire                         usiWCke,
	output wire [31:0]                  usiRd,
	output wire                         usiVd,
	output wire                         scl,
	inout  wire                         sda
);

	//------------------------------------------------------------
	// CSR to sequencer
	//------------------------------------------------------------
	wire        i2cEn;
	wire [15:0] div;
	wire [6:0]  tgtAdrs;
	wire [7:0]  txByte;
	wire        rdSel;
	wire        xferGo;
	wire        busy;
	wire [7:0]  rxByte;
	wire        nackPulse;

	// Sequencer to bit generator
	wire        symGo;
	wire [1:0]  sym;
	wire        txBit;
	wire        symDone;
	wire        rxBit;

	i2cCsr #(
		.blockAdrs	(blockAdrs)
	) csr (
		.sysClk(sysClk), .arstN(arstN),
		.usiAdrs(usiAdrs), .usiWd(usiWd), .usiWCke(usiWCke),
		.usiRd(usiRd), .usiVd(usiVd),
		.i2cEn(i2cEn), .div(div), .tgtAdrs(tgtAdrs), .txByte(txByte), .rdSel(rdSel),
		.xferGo(xferGo), .busy(busy), .rxByte(rxByte), .nackPulse(nackPulse)
	);

	i2cByteCtrl byteCtrl (
		.sysClk(sysClk), .arstN(arstN),
		.i2cEn(i2cEn), .xferGo(xferGo), .tgtAdrs(tgtAdrs), .txByte(txByte), .rdSel(rdSel),
		.busy(busy), .rxByte(rxByte), .nackPulse(nackPulse),
		.symGo(symGo), .sym(sym), .txBit(txBit), .symDone(symDone), .rxBit(rxBit)
	);

	i2cBitCtrl bitCtrl (
		.sysClk(sysClk), .arstN(arstN),
		.div(div), .symGo(symGo), .sym(sym), .txBit(txBit),
		.symDone(symDone), .rxBit(rxBit),
		.scl(scl), .sda(sda)			// External open-drain pair
	);

endmodule

`default_nettype wire

// File: tests/i2cTargetModel.sv
// Behavioral I2C target
// Fixed address; stores a written byte, answers reads with it inverted
`timescale 1ns/1ps
`default_nettype none

module i2cTargetModel #(
	parameter logic [6:0] devAdrs = 7'h50
)(
	input wire scl,
	inout wire sda
);

	localparam int PhIdle = 0, PhAdrs = 1, PhAdrsAck = 2, PhData = 3, PhDataAck = 4, PhDone = 5;

	int         phase   = PhIdle;
	logic [3:0] bitCnt  = '0;
	logic [7:0] shReg   = '0;
	logic [7:0] mem     = '0;		// Last written byte
	logic       matched = 1'b0;
	logic       readOp  = 1'b0;
	logic       drvLow  = 1'b0;
	logic [7:0] rdByte;

	assign sda    = drvLow ? 1'b0 : 1'bz;	// Open drain
	assign rdByte = ~mem;

	// START and STOP, SDA edges while SCL high
	always @(negedge sda)
	begin
		if (scl)
		begin
			phase   = PhAdrs;
			bitCnt  = '0;
			matched = 1'b0;
		end
	end

	always @(posedge sda)
	begin
		if (scl)
		begin
			phase  = PhIdle;
			drvLow = 1'b0;
		end
	end

	//------------------------------------------------------------
	// Sample on SCL rise
	//------------------------------------------------------------
	always @(posedge scl)
	begin
		case (phase)
			PhAdrs:
			begin
				shReg  = {shReg[6:0], sda};
				bitCnt = bitCnt + 4'd1;
				if (bitCnt == 4'd8)
				begin
					matched = (shReg[7:1] == devAdrs);
					readOp  = shReg[0];			// R/W bit
					phase   = PhAdrsAck;
				end
			end
			PhAdrsAck:
			begin
				phase  = PhData;
				bitCnt = '0;
			end
			PhData:
			begin
				shReg  = {shReg[6:0], sda};
				bitCnt = bitCnt + 4'd1;
				if (bitCnt == 4'd8)
				begin
					if (matched && !readOp)
						mem = shReg;
					phase = PhDataAck;
				end
			end
			PhDataAck: phase = PhDone;			// Master's ack or our ack seen
			default: ;
		endcase
	end

	// Drive only while SCL low
	always @(negedge scl)
	begin
		case (phase)
			PhAdrsAck: drvLow = matched;
			PhData:    drvLow = matched && readOp && !rdByte[3'd7 - bitCnt[2:0]];	// MSB first
			PhDataAck: drvLow = matched && !readOp;
			default:   drvLow = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: tests/i2cBlock_props.sv
// I2C block protocol checks
// Read pulse width, SDA stable under SCL high, idle bus level
`timescale 1ns/1ps
`default_nettype none

module i2cBlock_props (
	input wire       sysClk,
	input wire       arstN,
	input wire       usiVd,
	input wire       busy,
	input wire [1:0] sym,		// Symbol in flight
	input wire       scl,
	input wire       sda
);

	validPulse: assert property (@(posedge sysClk) disable iff (!arstN) usiVd |=> !usiVd)
		else $error("usiVd high for two cycles");

	// Only START and STOP move SDA with SCL high
	sdaStable: assert property (@(posedge sysClk) disable iff (!arstN)
		(scl && $past(scl) && sda != $past(sda))
		|-> (sym == i2cPkg::SymStart || sym == i2cPkg::SymStop))
		else $error("SDA changed while SCL high outside START/STOP");

	idleLines: assert property (@(posedge sysClk) disable iff (!arstN) !busy |-> (scl && sda))
		else $error("bus lines not idle while block not busy");

endmodule

bind i2cBlock i2cBlock_props props (
	.sysClk(sysClk), .arstN(arstN), .usiVd(usiVd), .busy(busy),
	.sym(sym), .scl(scl), .sda(sda)
);

`default_nettype wire

// File: tests/i2cBlockTb.sv
// I2C block testbench
// Runs bus operations from a pattern file against the block and an I2C target model
`timescale 1ns/1ps
`default_nettype none
`include "i2c_macros.svh"

module i2cBlockTb;

	localparam int    ClkHalf     = 50;		// 100 ns period
	localparam int    ResetCycles = 16;
	localparam string PatFile     = "tests/i2cPatterns.txt";

	logic        sysClk;
	logic        arstN;
	logic [31:0] usiAdrs;
	logic [31:0] usiWd;
	logic        usiWCke;
	wire  [31:0] usiRd;
	wire         usiVd;
	wire         scl;
	tri1         sda;					// Bus pull-up

	logic [7:0]  opQ[$];				// W, R or P
	logic [23:0] locQ[$];				// Block select and offset
	logic [31:0] valQ[$];

	int     checks     = 0;
	int     valueErrs  = 0;
	int     otherErrs  = 0;
	longint watchLimit = 0;				// ns, zero until patterns are loaded

	i2cBlock #(
		.blockAdrs	(`I2C_DEF_BLOCK_ADRS)
	) UUT (
		.sysClk(sysClk), .arstN(arstN),
		.usiAdrs(usiAdrs), .usiWd(usiWd), .usiWCke(usiWCke),
		.usiRd(usiRd), .usiVd(usiVd),
		.scl(scl), .sda(sda)
	);

	i2cTargetModel #(.devAdrs(7'h50)) target (.scl(scl), .sda(sda));

	always #ClkHalf sysClk = ~sysClk;

	//------------------------------------------------------------
	// Bus access, driven on falling edges
	//------------------------------------------------------------
	task automatic busWrite(input logic [23:0] loc, input logic [31:0] data);
		@(negedge sysClk);
		usiAdrs = {`I2C_CMD_WRITE, 6'd0, loc};
		usiWd   = data;
		usiWCke = 1'b1;
		@(negedge sysClk);
		usiWCke = 1'b0;
	endtask

	// Response sits one cycle after the strobe edge
	task automatic busRead(input logic [23:0] loc, output logic [31:0] data, output logic valid);
		@(negedge sysClk);
		usiAdrs = {`I2C_CMD_READ, 6'd0, loc};
		usiWCke = 1'b1;
		@(negedge sysClk);
		usiWCke = 1'b0;
		valid   = usiVd;
		data    = usiRd;
	endtask

	task automatic checkRead(input logic [23:0] loc, input logic [31:0] got,
	                         input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			valueErrs++;
			$display("[FAIL] usiRd @ 0x%06h got 0x%08h expected 0x%08h", loc, got, exp);
		end
	endtask

	task automatic reportNoValid(input logic [23:0] loc);
		otherErrs++;
		$display("Error: read of 0x%06h got no usiVd pulse at %0t ns", loc, $time);
	endtask

	// Busy is STATUS bit 0
	task automatic pollStatus(input logic [23:0] loc, input logic [31:0] exp);
		logic [31:0] data;
		logic        valid;
		data  = 32'h1;
		valid = 1'b1;
		while (valid && data[0])
			busRead(loc, data, valid);
		if (!valid)
			reportNoValid(loc);
		else
			checkRead(loc, data, exp);
	endtask

	task automatic runPattern(input int idx);
		logic [31:0] data;
		logic        valid;
		case (opQ[idx])
			"W": busWrite(locQ[idx], valQ[idx]);
			"R":
			begin
				busRead(locQ[idx], data, valid);
				if (!valid)
					reportNoValid(locQ[idx]);
				else
					checkRead(locQ[idx], data, valQ[idx]);
			end
			"P": pollStatus(locQ[idx], valQ[idx]);
			default:
			begin
				otherErrs++;
				$display("Error: unknown operation in pattern line %0d", idx);
			end
		endcase
	endtask

	//------------------------------------------------------------
	// Pattern file
	//------------------------------------------------------------
	task automatic loadPatterns(output int ok);
		int          fd;
		int          code;
		string       line;
		logic [7:0]  op;
		logic [23:0] loc;
		logic [31:0] val;
		ok = 0;
		fd = $fopen(PatFile, "r");
		if (fd == 0)
		begin
			otherErrs++;
			$display("Error: cannot open %s", PatFile);
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line[0] != "#")	// Skip comments, blanks
				begin
					code = $sscanf(line, "%c %h %h", op, loc, val);
					if (code == 3)
					begin
						opQ.push_back(op);
						locQ.push_back(loc);
						valQ.push_back(val);
					end
					else
					begin
						otherErrs++;
						$display("Error: malformed pattern line: %s", line);
					end
				end
			end
			$fclose(fd);
			ok = 1;
		end
	endtask

	// Slowest divider written to this block, sets the watchdog budget
	function automatic int largestDiv();
		int          most;
		logic [23:0] loc;
		logic [31:0] val;
		most = 2;
		foreach (opQ[i])
		begin
			loc = locQ[i];
			val = valQ[i];
			if (opQ[i] == "W" && loc[15:0] == `I2C_CSR_DIV
			    && loc[23:16] == `I2C_DEF_BLOCK_ADRS && int'(val[15:0]) > most)
				most = int'(val[15:0]);
		end
		return most;
	endfunction

	//------------------------------------------------------------
	// Watchdog
	//------------------------------------------------------------
	initial
	begin
		wait (watchLimit != 0);
		#(watchLimit);
		$display("Error: watchdog expired after %0d ns, run did not finish", watchLimit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		int loaded;
		sysClk  = 1'b0;
		arstN   = 1'b0;
		usiAdrs = '0;
		usiWd   = '0;
		usiWCke = 1'b0;
		loadPatterns(loaded);
		if (loaded != 0)	// 80 quarters of div per transfer, doubled, plus reset
			watchLimit = longint'(opQ.size()) * 80 * largestDiv() * 100 * 2
			             + ResetCycles * 100 * 2;
		repeat (ResetCycles) @(negedge sysClk);
		arstN = 1'b1;
		for (int i = 0; i < opQ.size(); i++)
			runPattern(i);
		repeat (4) @(negedge sysClk);
		$display("Checks %0d, value errors %0d, other errors %0d", checks, valueErrs, otherErrs);
		if (valueErrs == 0 && otherErrs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/i2cPatterns.txt
# op loc value: W write, R read and compare, P poll STATUS until not busy then compare
# loc is block select (23:16) and CSR offset (15:0); loc and value in hex
W 010000 00000001
W 010004 00000004
W 010008 00000050
R 010000 00000001
R 010004 00000004
R 010008 00000050
R 010014 00000000
W 020004 00000009
R 010004 00000004
W 01000C 0000003C
P 010010 00000000
W 01000C 00000100
P 010010 0000C300
W 010008 00000022
W 01000C 000000A5
P 010010 0000C302
W 010000 00000000
W 010008 00000050
W 01000C 0000003C
P 010010 0000C302
W 010000 00000001
W 01000C 0000003C
P 010010 0000C300
W 010004 00000007
W 01000C 0000003C
P 010010 0000C300
W 01000C 00000100
P 010010 0000C300

// File: src.f
+incdir+hdl
hdl/i2cPkg.sv
hdl/i2cCsr.sv
hdl/i2cByteCtrl.sv
hdl/i2cBitCtrl.sv
hdl/i2cBlock.sv
tests/i2cTargetModel.sv
tests/i2cBlock_props.sv
tests/i2cBlockTb.sv

// File: Makefile
# Verilator build and run of the I2C block testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench, log in sim.log"
	@echo "  clean  remove the build directory and the log"

# A simulator error exit also counts as a failure
test:
	verilator --binary --assert -f src.f --top-module i2cBlockTb -o simv
	./obj_dir/simv > sim.log 2>&1 || echo "*** TEST FAILED ***" >> sim.log
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
